/* Makefile */
# Verilator flow for the scratch memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FLIST     ?= build.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_mem_subsystem.sv */
// Scratch memory testbench

`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int width_lp = 32;
    localparam int els_lp   = 16;
    localparam int subs_lp  = 2;
    // the tests take about 120 cycles so this limit leaves a wide margin
    localparam int timeout_cycles_lp = 2000;

    logic                 clk;
    logic                 arst_n_i;
    logic                 clear_i;
    logic [1:0]           v_i;
    logic                 w_i;
    logic [3:0]           addr_i;
    logic [1:0][15:0]     data_i;
    logic [1:0][1:0]      w_mask_i;  // two bytes per subbank
    logic [1:0][15:0]     data_o;
    logic                 busy_o;

    logic [31:0] model [els_lp];     // expected array contents
    logic [31:0] rng;                // xorshift state
    int          cycles;

    mem_subsystem_top #(
        .width_p(width_lp), .els_p(els_lp), .num_subbank_p(subs_lp), .latch_last_read_p(1)
    ) u_dut (
        .clk_i(clk), .arst_n_i(arst_n_i), .clear_i(clear_i), .v_i(v_i), .w_i(w_i),
        .addr_i(addr_i), .data_i(data_i), .w_mask_i(w_mask_i), .data_o(data_o),
        .busy_o(busy_o)
    );

    always #50 clk = ~clk;

    // runaway guard counting every rising edge
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles_lp) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles_lp);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // one write cycle with the model following the byte and valid rule
    task automatic write_word(input logic [3:0] a, input logic [31:0] d, input logic [1:0] v,
                              input logic [3:0] m);
        addr_i   = a;
        data_i   = d;
        v_i      = v;
        w_i      = 1'b1;
        w_mask_i = m;
        for (int b = 0; b < 4; b++) begin
            if (v[b/2] && m[b]) model[a][b*8 +: 8] = d[b*8 +: 8];  // byte b sits in subbank b/2
        end
        @(negedge clk);
        v_i = '0;
        w_i = 1'b0;
    endtask

    // data is sampled half a cycle after the edge that registered it
    task automatic read_word(input logic [3:0] a, input logic [1:0] v, output logic [31:0] rd);
        addr_i = a;
        v_i    = v;
        w_i    = 1'b0;
        @(negedge clk);
        v_i = '0;
        rd  = data_o;
    endtask

    task automatic test_clear();
        int          busy_cycles;
        logic [31:0] rd;
        busy_cycles = 0;
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
        while (busy_o) begin
            busy_cycles++;
            @(negedge clk);
        end
        check_equal("test_clear busy", els_lp, busy_cycles);
        for (int a = 0; a < els_lp; a++) model[a] = '0;
        for (int a = 0; a < els_lp; a++) begin
            read_word(4'(a), 2'b11, rd);
            check_equal("test_clear", model[a], rd);
        end
    endtask

    task automatic test_full_rw();
        logic [31:0] rd;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            write_word(rng[3:0], xorshift32(rng), 2'b11, 4'hf);  // address and data differ
        end
        for (int a = 0; a < els_lp; a++) begin
            read_word(4'(a), 2'b11, rd);
            check_equal("test_full_rw", model[a], rd);
        end
    endtask

    task automatic test_byte_mask();
        logic [31:0] rd;
        logic [3:0]  a;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            a   = rng[3:0];
            write_word(a, 32'h5a5a_a5a5 ^ {8{a}}, 2'b11, 4'hf);  // known background
            rng = xorshift32(rng);
            write_word(a, rng, 2'b11, rng[7:4]);
            read_word(a, 2'b11, rd);
            check_equal("test_byte_mask", model[a], rd);
        end
    endtask

    task automatic test_subbank_valid();
        logic [31:0] rd;
        logic [3:0]  a;
        for (int s = 0; s < subs_lp; s++) begin
            rng = xorshift32(rng);
            a   = rng[3:0];
            rng = xorshift32(rng);
            write_word(a, rng, 2'(1 << s), 4'hf);  // the other half must survive
            read_word(a, 2'b11, rd);
            check_equal("test_subbank_valid", model[a], rd);
        end
    endtask

    task automatic test_latch_last_read();
        logic [31:0] rd;
        logic [15:0] held;
        logic [3:0]  a;
        rng = xorshift32(rng);
        a   = rng[3:0];
        read_word(a, 2'b01, rd);
        held = rd[15:0];
        check_equal("test_latch_last_read read", {16'h0, model[a][15:0]}, {16'h0, held});
        write_word(a, ~model[a], 2'b11, 4'hf);
        repeat (3) @(negedge clk);
        check_equal("test_latch_last_read idle", {16'h0, held}, {16'h0, data_o[0]});
        read_word(a + 4'd1, 2'b10, rd);  // only subbank one is read so subbank zero keeps its word
        check_equal("test_latch_last_read other", {16'h0, held}, {16'h0, data_o[0]});
    endtask

    task automatic test_busy_drop();
        int          busy_cycles;
        logic [31:0] rd;
        busy_cycles = 0;
        clear_i = 1'b1;
        @(negedge clk);
        clear_i = 1'b0;
        while (busy_o) begin
            v_i     = '0;
            w_i     = 1'b0;
            clear_i = 1'b0;
            // addresses 0 to 3 are already swept when these writes arrive
            if (busy_cycles >= 8 && busy_cycles < 12) begin
                rng      = xorshift32(rng);
                v_i      = 2'b11;
                w_i      = 1'b1;
                addr_i   = 4'(busy_cycles - 8);
                data_i   = rng | 32'h1;
                w_mask_i = '1;
            end
            if (busy_cycles == 10) clear_i = 1'b1;  // second clear during the sweep
            busy_cycles++;
            @(negedge clk);
        end
        v_i     = '0;
        w_i     = 1'b0;
        clear_i = 1'b0;
        check_equal("test_busy_drop busy", els_lp, busy_cycles);
        for (int a = 0; a < els_lp; a++) model[a] = '0;
        for (int a = 0; a < 4; a++) begin
            read_word(4'(a), 2'b11, rd);
            check_equal("test_busy_drop", model[a], rd);
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n_i = 1'b0;
        clear_i  = 1'b0;
        v_i      = '0;
        w_i      = 1'b0;
        addr_i   = '0;
        data_i   = '0;
        w_mask_i = '0;
        cycles   = 0;
        rng      = 32'hb944_a649;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        test_clear();
        test_full_rw();
        test_byte_mask();
        test_subbank_valid();
        test_latch_last_read();
        test_busy_drop();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* build.f */
hdl/mem_geom_pkg.sv
hdl/mem_ctrl_pkg.sv
hdl/sram_port_if.sv
hdl/addr_counter.sv
hdl/clear_sequencer.sv
hdl/byte_mask_bank.sv
hdl/read_latch.sv
hdl/mem_1rw_sync_subbanked.sv
hdl/mem_subsystem_top.sv
bench/tb_mem_subsystem.sv

/* hdl/addr_counter.sv */
// Sweep address counter

`timescale 1ns/1ns

module addr_counter #(
    parameter int els_p = 16
) (
    input  logic                                       clk_i,
    input  logic                                       arst_n_i,
    input  logic                                       clr_i,   // back to address zero
    input  logic                                       en_i,    // step to the next address
    output logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] count_o,
    output logic                                       last_o
);

    localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
    localparam logic [addr_w_lp-1:0] last_lp = addr_w_lp'(els_p - 1);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0; // clear wins over enable
        end else if (en_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign last_o = (count_o == last_lp); // top of the array

    // the owner must stop stepping at the last address instead of wrapping
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(en_i && last_o && !clr_i));

endmodule

/* hdl/byte_mask_bank.sv */
// Byte masked storage array

`timescale 1ns/1ns

module byte_mask_bank import mem_geom_pkg::*; #(
    parameter int width_p = WIDTH_DEF,
    parameter int els_p   = ELS_DEF
) (
    input  logic                                         clk_i,
    input  logic                                         v_i,
    input  logic                                         w_i,
    input  logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] addr_i,
    input  logic [width_p-1:0]                           data_i,
    input  logic [width_p/BYTE_W-1:0]                    w_mask_i, // one bit per byte
    output logic [width_p-1:0]                           data_o
);

    localparam int bytes_lp = width_p / BYTE_W;

    logic [width_p-1:0] mem_r [els_p]; // contents only change by write or sweep

    // write side updates only the enabled bytes
    always_ff @(posedge clk_i) begin
        if (v_i && w_i) begin
            for (int b = 0; b < bytes_lp; b++) begin
                if (w_mask_i[b]) begin
                    mem_r[addr_i][b*BYTE_W +: BYTE_W] <= data_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // read word lands one edge after the request
    always_ff @(posedge clk_i) begin
        if (v_i && !w_i) begin
            data_o <= mem_r[addr_i];
        end
    end

    // both the user path and the sweep counter have to stay inside the array
    a_addr_in_range: assert property (@(posedge clk_i)
        v_i |-> (addr_i < els_p));

endmodule

/* hdl/clear_sequencer.sv */
// Clear sequencer and access mux

`timescale 1ns/1ns

module clear_sequencer import mem_geom_pkg::*, mem_ctrl_pkg::*; #(
    parameter int width_p       = WIDTH_DEF,
    parameter int els_p         = ELS_DEF,
    parameter int num_subbank_p = SUBBANKS_DEF
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 clear_i,
    input  logic [num_subbank_p-1:0]             v_i,
    input  logic                                 w_i,
    input  logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] addr_i,
    input  logic [num_subbank_p-1:0][width_p/num_subbank_p-1:0] data_i,
    input  logic [num_subbank_p-1:0][width_p/num_subbank_p/BYTE_W-1:0] w_mask_i,
    output logic                                 busy_o,
    sram_port_if.host                            mem
);

    localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

    seq_state_e           state_r;
    logic                 busy_r;   // registered busy flag, high for the whole sweep
    logic [addr_w_lp-1:0] sweep_addr;
    logic                 sweep_last;
    logic                 sweeping;

    assign sweeping = (state_r == SWEEP);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r <= IDLE;
            busy_r  <= 1'b0;
        end else begin
            case (state_r)
                IDLE: if (clear_i) begin
                    state_r <= SWEEP; // busy rises right after the sampling edge
                    busy_r  <= 1'b1;
                end
                SWEEP: if (sweep_last) begin
                    state_r <= DONE;  // this edge writes the last address
                    busy_r  <= 1'b0;
                end
                default: state_r <= IDLE; // clear requests are not taken in done
            endcase
        end
    end

    // counter sits at zero outside the sweep and parks on the last address
    addr_counter #(.els_p(els_p)) u_addr_cnt (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clr_i    (!sweeping),
        .en_i     (sweeping && !sweep_last),
        .count_o  (sweep_addr),
        .last_o   (sweep_last)
    );

    always_comb begin
        if (sweeping) begin
            mem.v      = '1; // every subbank and every byte takes the fill word
            mem.w      = 1'b1;
            mem.addr   = sweep_addr;
            mem.data   = {width_p{FILL_WORD_BIT}};
            mem.w_mask = '1;
        end else begin
            mem.v      = v_i; // user access goes straight through
            mem.w      = w_i;
            mem.addr   = addr_i;
            mem.data   = data_i;
            mem.w_mask = w_mask_i;
        end
    end

    assign busy_o = busy_r;

    a_idle_not_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_r == IDLE) |-> !busy_o);

endmodule

/* hdl/mem_1rw_sync_subbanked.sv */
// Width subbanked single port memory

`timescale 1ns/1ns

module mem_1rw_sync_subbanked import mem_geom_pkg::*; #(
    parameter int width_p           = WIDTH_DEF,
    parameter int els_p             = ELS_DEF,
    parameter int num_subbank_p     = SUBBANKS_DEF,
    parameter int latch_last_read_p = 0
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    sram_port_if.bank mem
);

    localparam int sub_w_lp  = width_p / num_subbank_p;
    localparam int mask_w_lp = sub_w_lp / BYTE_W;

    logic [num_subbank_p-1:0][mask_w_lp-1:0] w_mask_lo; // masks gated by subbank valid
    logic [num_subbank_p-1:0][sub_w_lp-1:0]  data_lo;   // raw bank output

    for (genvar i = 0; i < num_subbank_p; i++) begin : g_mask
        if (num_subbank_p == 1) begin : g_full
            assign w_mask_lo[i] = '1; // one subbank means whole word writes
        end else begin : g_gated
            assign w_mask_lo[i] = mem.w_mask[i] & {mask_w_lp{mem.v[i]}};
        end
    end

    byte_mask_bank #(.width_p(width_p), .els_p(els_p)) u_bank (
        .clk_i    (clk_i),
        .v_i      (|mem.v),  // any subbank valid makes an access
        .w_i      (mem.w),
        .addr_i   (mem.addr),
        .data_i   (mem.data),
        .w_mask_i (w_mask_lo),
        .data_o   (data_lo)
    );

    if (latch_last_read_p != 0) begin : g_llr
        logic [num_subbank_p-1:0] read_en;
        for (genvar i = 0; i < num_subbank_p; i++) begin : g_sub
            assign read_en[i] = mem.v[i] & ~mem.w; // only a read of this subbank refreshes it
            read_latch #(.sub_width_p(sub_w_lp)) u_latch (
                .clk_i    (clk_i),
                .arst_n_i (arst_n_i),
                .read_i   (read_en[i]),
                .data_i   (data_lo[i]),
                .data_o   (mem.rdata[i])
            );
        end
    end else begin : g_no_llr
        assign mem.rdata = data_lo; // output is only meaningful right after a read
    end

    if (num_subbank_p == 0) $error("num_subbank_p must not be zero");
    if ((width_p & (width_p - 1)) != 0) $error("width_p must be a power of two");
    if ((els_p & (els_p - 1)) != 0) $error("els_p must be a power of two");
    if ((sub_w_lp % BYTE_W) != 0) $error("subbank width must be a multiple of 8");

endmodule

/* hdl/mem_ctrl_pkg.sv */
// Clear sequencer definitions

package mem_ctrl_pkg;

    // done lasts one cycle and is where busy has already dropped
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // user owns the port
        SWEEP = 2'd1, // zero fill in progress
        DONE  = 2'd2
    } seq_state_e;

    // every bit of the array is set to this during a clear
    parameter logic FILL_WORD_BIT = 1'b0;

endpackage

/* hdl/mem_geom_pkg.sv */
// Memory geometry defaults

package mem_geom_pkg;

    // total data width of one memory word
    parameter int WIDTH_DEF = 32;

    // number of words in the array
    parameter int ELS_DEF = 16;

    parameter int SUBBANKS_DEF = 2; // width subbanks sharing one address

    // one write mask bit covers this many data bits
    parameter int BYTE_W = 8;

endpackage

/* hdl/mem_subsystem_top.sv */
// Scratch memory subsystem

`timescale 1ns/1ns

module mem_subsystem_top import mem_geom_pkg::*; #(
    parameter int width_p           = WIDTH_DEF,
    parameter int els_p             = ELS_DEF,
    parameter int num_subbank_p     = SUBBANKS_DEF,
    parameter int latch_last_read_p = 1
) (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  logic                                         clear_i,  // starts a zero fill
    input  logic [num_subbank_p-1:0]                     v_i,
    input  logic                                         w_i,
    input  logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] addr_i,
    input  logic [num_subbank_p-1:0][width_p/num_subbank_p-1:0] data_i,
    input  logic [num_subbank_p-1:0][width_p/num_subbank_p/BYTE_W-1:0] w_mask_i,
    output logic [num_subbank_p-1:0][width_p/num_subbank_p-1:0] data_o,
    output logic                                         busy_o    // user access dropped while high
);

    // single access path between the sequencer and the memory
    sram_port_if #(
        .width_p(width_p), .els_p(els_p), .num_subbank_p(num_subbank_p)
    ) mem_bus ();

    clear_sequencer #(
        .width_p(width_p), .els_p(els_p), .num_subbank_p(num_subbank_p)
    ) u_seq (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clear_i  (clear_i),
        .v_i      (v_i),
        .w_i      (w_i),
        .addr_i   (addr_i),
        .data_i   (data_i),
        .w_mask_i (w_mask_i),
        .busy_o   (busy_o),
        .mem      (mem_bus.host)
    );

    mem_1rw_sync_subbanked #(
        .width_p(width_p), .els_p(els_p), .num_subbank_p(num_subbank_p),
        .latch_last_read_p(latch_last_read_p)
    ) u_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .mem      (mem_bus.bank)
    );

    assign data_o = mem_bus.rdata; // read data skips the sequencer

endmodule

/* hdl/read_latch.sv */
// Last read hold with bypass

`timescale 1ns/1ns

module read_latch #(
    parameter int sub_width_p = 16
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   read_i,  // read issued in this cycle
    input  logic [sub_width_p-1:0] data_i,  // registered bank output
    output logic [sub_width_p-1:0] data_o
);

    logic                   read_r; // high in the cycle the bank output is fresh
    logic [sub_width_p-1:0] hold_r;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_r <= 1'b0;
        end else begin
            read_r <= read_i;
        end
    end

    // keep a copy of the fresh word for the cycles that follow
    always_ff @(posedge clk_i) begin
        if (read_r) begin
            hold_r <= data_i;
        end
    end

    // fresh data goes out without an extra cycle of delay
    assign data_o = read_r ? data_i : hold_r;

endmodule

/* hdl/sram_port_if.sv */
// SRAM access port

`timescale 1ns/1ns

interface sram_port_if import mem_geom_pkg::*; #(
    parameter int width_p       = WIDTH_DEF,
    parameter int els_p         = ELS_DEF,
    parameter int num_subbank_p = SUBBANKS_DEF
) ();

    localparam int sub_w_lp  = width_p / num_subbank_p;
    localparam int mask_w_lp = sub_w_lp / BYTE_W;
    localparam int addr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

    logic [num_subbank_p-1:0]                v;      // one valid per subbank
    logic                                    w;      // write when set, read otherwise
    logic [addr_w_lp-1:0]                    addr;   // shared by every subbank
    logic [num_subbank_p-1:0][sub_w_lp-1:0]  data;
    logic [num_subbank_p-1:0][mask_w_lp-1:0] w_mask; // byte enables within each subbank
    logic [num_subbank_p-1:0][sub_w_lp-1:0]  rdata;

    // the sequencer side issues accesses
    modport host (output v, w, addr, data, w_mask, input rdata);

    // the memory side answers them
    modport bank (input v, w, addr, data, w_mask, output rdata);

endinterface
